/* common/palette_pkg.sv */
package palette_pkg;

	//////////////////////////////////////////////////////////////////////
	// Colour lookup types
	//////////////////////////////////////////////////////////////////////

	// Two banks of 256 entries
	localparam int unsigned PROM_DEPTH = 512;

	// Mixer output, PROM low address bits
	typedef logic [7:0] clut_index_t;

	// Bank bit on top of the index
	typedef struct packed {
		logic        bank;
		clut_index_t index;
	} prom_addr_t;

	// Red/green PROM, green in the high nibble
	typedef struct packed {
		logic [3:0] green;
		logic [3:0] red;
	} prom_rg_t;

	// Blue PROM, one nibble
	typedef struct packed {
		logic [3:0] blue;
	} prom_b_t;

	// Final video, sync is composite (hsync OR vsync)
	typedef struct packed {
		logic       sync;
		logic       blank;
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} video_out_t;

endpackage

/* common/video_pkg.sv */
package video_pkg;

	//////////////////////////////////////////////////////////////////////
	// Raster geometry
	//////////////////////////////////////////////////////////////////////

	// Horizontal, in pixel clocks
	localparam int unsigned H_TOTAL      = 64;
	localparam int unsigned H_ACTIVE     = 48;
	localparam int unsigned H_SYNC_START = 52;
	localparam int unsigned H_SYNC_END   = 58;

	// Vertical, in lines
	localparam int unsigned V_TOTAL      = 40;
	localparam int unsigned V_ACTIVE     = 32;
	localparam int unsigned V_SYNC_START = 34;
	localparam int unsigned V_SYNC_END   = 36;

	// Counter widths
	localparam int unsigned HCOUNT_W = 6;
	localparam int unsigned VCOUNT_W = 6;

	// Layer count and beam-to-video delay
	localparam int unsigned NUM_LAYERS   = 4;
	localparam int unsigned PIPE_LATENCY = 4;

	typedef logic [HCOUNT_W-1:0] hcount_t;
	typedef logic [VCOUNT_W-1:0] vcount_t;

	// Beam position plus decoded flags
	typedef struct packed {
		hcount_t hcount;
		vcount_t vcount;
		logic    hsync;
		logic    vsync;
		logic    blank;
	} beam_t;

	//////////////////////////////////////////////////////////////////////
	// Layers and host writes
	//////////////////////////////////////////////////////////////////////

	// Colour 0 is transparent
	typedef struct packed {
		logic [7:0] color;
		logic [1:0] prio;
	} layer_pixel_t;

	// Decoded write for one layer
	typedef struct packed {
		logic       ram_we;
		logic       ctrl_we;
		logic [8:0] addr;
		logic [7:0] data;
	} layer_wr_t;

	// Host write destinations
	typedef enum logic [2:0] {
		TGT_LAYER_RAM  = 3'd0,
		TGT_LAYER_CTRL = 3'd1,
		TGT_PROM_RG    = 3'd2,
		TGT_PROM_B     = 3'd3,
		TGT_BANK       = 3'd4
	} host_target_e;

	// Raw host write, single-cycle strobe
	typedef struct packed {
		logic         strobe;
		host_target_e target;
		logic [1:0]   layer;
		logic [8:0]   addr;
		logic [7:0]   data;
	} host_wr_t;

endpackage

/* hw/clut/clut_stage.sv */
`timescale 1ns/1ps

module clut_stage (
	input  logic                     clk_6md,
	input  logic                     reset,
	input  palette_pkg::clut_index_t index,
	input  video_pkg::beam_t         beam,
	input  logic                     bank,
	output palette_pkg::prom_addr_t  prom_addr,
	input  palette_pkg::prom_rg_t    prom_rg,
	input  palette_pkg::prom_b_t     prom_b,
	output palette_pkg::video_out_t  video
);

	// Index latch ahead of the PROMs
	palette_pkg::clut_index_t index_q;

	// Flags, one stage per pipeline step
	logic sync_q1;
	logic blank_q1;
	logic sync_q2;
	logic blank_q2;

	//////////////////////////////////////////////////////////////////////
	// Index register and PROM address
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_6md) begin
		if (reset) begin
			index_q <= '0;
		end else begin
			index_q <= index;
		end
	end

	// Bank selects the upper 256 entries
	assign prom_addr.bank  = bank;
	assign prom_addr.index = index_q;

	//////////////////////////////////////////////////////////////////////
	// Sync and blank delay
	//////////////////////////////////////////////////////////////////////

	// Matches index register then PROM read
	always_ff @(posedge clk_6md) begin
		if (reset) begin
			sync_q1  <= 1'b0;
			blank_q1 <= 1'b0;
			sync_q2  <= 1'b0;
			blank_q2 <= 1'b0;
		end else begin
			sync_q1  <= beam.hsync | beam.vsync;
			blank_q1 <= beam.blank;
			sync_q2  <= sync_q1;
			blank_q2 <= blank_q1;
		end
	end

	// PROM outputs already registered, RGB not forced in blanking
	assign video.sync  = sync_q2;
	assign video.blank = blank_q2;
	assign video.red   = prom_rg.red;
	assign video.green = prom_rg.green;
	assign video.blue  = prom_b.blue;

endmodule

/* hw/clut/sync_rom.sv */
`timescale 1ns/1ps

module sync_rom #(
	parameter type entry_t = logic [7:0]
) (
	input  logic                    clk_6md,
	input  logic                    we,
	input  palette_pkg::prom_addr_t waddr,
	input  entry_t                  wdata,
	input  palette_pkg::prom_addr_t raddr,
	output entry_t                  rdata
);

	// Both banks in one array
	entry_t mem [palette_pkg::PROM_DEPTH];

	//////////////////////////////////////////////////////////////////////
	// Host load port
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_6md) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read port
	//////////////////////////////////////////////////////////////////////

	// Output register plays the part of the RGB latches
	always_ff @(posedge clk_6md) begin
		rdata <= mem[raddr];
	end

endmodule

/* hw/host_regs.sv */
`timescale 1ns/1ps

module host_regs (
	input  logic                    clk_6md,
	input  logic                    reset,
	input  video_pkg::host_wr_t     host_wr,
	output video_pkg::layer_wr_t    layer_wr [video_pkg::NUM_LAYERS],
	output logic                    prom_rg_we,
	output logic                    prom_b_we,
	output palette_pkg::prom_addr_t prom_waddr,
	output logic [7:0]              prom_wdata,
	output logic                    bank
);

	// Decode before the register
	video_pkg::layer_wr_t layer_wr_d [video_pkg::NUM_LAYERS];
	logic                 bank_we_q;
	logic                 bank_data_q;

	//////////////////////////////////////////////////////////////////////
	// Target decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < video_pkg::NUM_LAYERS; i++) begin
			// Only the addressed layer sees a strobe
			layer_wr_d[i].ram_we  = host_wr.strobe && (host_wr.layer == i) &&
				(host_wr.target == video_pkg::TGT_LAYER_RAM);
			layer_wr_d[i].ctrl_we = host_wr.strobe && (host_wr.layer == i) &&
				(host_wr.target == video_pkg::TGT_LAYER_CTRL);
			layer_wr_d[i].addr    = host_wr.addr;
			layer_wr_d[i].data    = host_wr.data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Registered write stage
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_6md) begin
		if (reset) begin
			layer_wr    <= '{default: '0};
			prom_rg_we  <= 1'b0;
			prom_b_we   <= 1'b0;
			bank_we_q   <= 1'b0;
		end else begin
			layer_wr    <= layer_wr_d;
			prom_rg_we  <= host_wr.strobe && (host_wr.target == video_pkg::TGT_PROM_RG);
			prom_b_we   <= host_wr.strobe && (host_wr.target == video_pkg::TGT_PROM_B);
			bank_we_q   <= host_wr.strobe && (host_wr.target == video_pkg::TGT_BANK);
		end
	end

	// PROM address and data, shared by both PROMs
	always_ff @(posedge clk_6md) begin
		prom_waddr  <= palette_pkg::prom_addr_t'(host_wr.addr);
		prom_wdata  <= host_wr.data;
		bank_data_q <= host_wr.data[0];
	end

	// Bank bit, lands on the second edge like the other targets
	always_ff @(posedge clk_6md) begin
		if (reset) begin
			bank <= 1'b0;
		end else if (bank_we_q) begin
			bank <= bank_data_q;
		end
	end

endmodule

/* hw/layer/layer_fetch.sv */
`timescale 1ns/1ps

module layer_fetch (
	input  logic                    clk_6md,
	input  logic                    reset,
	input  video_pkg::beam_t        beam,
	input  video_pkg::layer_wr_t    wr,
	output video_pkg::layer_pixel_t pixel
);

	// 16 x 16 pattern, one colour index per cell
	logic [7:0] pattern_ram [256];

	// Layer control
	logic [7:0] scroll_x;
	logic [1:0] prio_q;

	// Scrolled column and read address
	logic [7:0] col_sum;
	logic [7:0] rd_addr;

	//////////////////////////////////////////////////////////////////////
	// Host side
	//////////////////////////////////////////////////////////////////////

	// Pattern writes, low 8 address bits
	always_ff @(posedge clk_6md) begin
		if (wr.ram_we) begin
			pattern_ram[wr.addr[7:0]] <= wr.data;
		end
	end

	// Control registers, addr 0 scroll, addr 1 priority
	always_ff @(posedge clk_6md) begin
		if (reset) begin
			scroll_x <= '0;
			prio_q   <= '0;
		end else if (wr.ctrl_we) begin
			if (wr.addr == 9'd0) begin
				scroll_x <= wr.data;
			end
			if (wr.addr == 9'd1) begin
				prio_q <= wr.data[1:0];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Beam side
	//////////////////////////////////////////////////////////////////////

	// Horizontal scroll only
	assign col_sum = {2'b00, beam.hcount} + scroll_x;

	// Row in the high nibble, column in the low nibble
	assign rd_addr = {beam.vcount[3:0], col_sum[3:0]};

	// One-cycle fetch
	always_ff @(posedge clk_6md) begin
		if (reset) begin
			pixel <= '0;
		end else begin
			pixel.color <= pattern_ram[rd_addr];
			pixel.prio  <= prio_q;
		end
	end

endmodule

/* hw/priority_mixer.sv */
`timescale 1ns/1ps

module priority_mixer (
	input  logic                      clk_6md,
	input  logic                      reset,
	input  video_pkg::beam_t          beam,
	input  video_pkg::layer_pixel_t   pixels [video_pkg::NUM_LAYERS],
	output palette_pkg::clut_index_t  index,
	output video_pkg::beam_t          beam_out
);

	// Winner so far
	video_pkg::layer_pixel_t best;
	logic                    found;

	// Beam held back to line up with the layer pixels
	video_pkg::beam_t        beam_q;

	//////////////////////////////////////////////////////////////////////
	// Priority select
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		found = 1'b0;
		best  = '0;
		// Ascending scan, strict compare keeps lower layer on a tie
		for (int i = 0; i < video_pkg::NUM_LAYERS; i++) begin
			if ((pixels[i].color != '0) && (!found || (pixels[i].prio > best.prio))) begin
				found = 1'b1;
				best  = pixels[i];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_6md) begin
		if (reset) begin
			beam_q   <= '0;
			index    <= '0;
			beam_out <= '0;
		end else begin
			// All transparent leaves best cleared, so index 0
			index    <= best.color;
			// Layer fetch delay, then this stage
			beam_q   <= beam;
			beam_out <= beam_q;
		end
	end

endmodule

/* hw/video_timing.sv */
`timescale 1ns/1ps

module video_timing (
	input  logic             clk_6md,
	input  logic             reset,
	output video_pkg::beam_t beam
);

	// Position for the next cycle
	video_pkg::hcount_t h_next;
	video_pkg::vcount_t v_next;

	//////////////////////////////////////////////////////////////////////
	// Raster counters
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		if (beam.hcount == video_pkg::hcount_t'(video_pkg::H_TOTAL - 1)) begin
			// End of line, wrap and step vertically
			h_next = '0;
			if (beam.vcount == video_pkg::vcount_t'(video_pkg::V_TOTAL - 1)) begin
				v_next = '0;
			end else begin
				v_next = beam.vcount + video_pkg::vcount_t'(1);
			end
		end else begin
			h_next = beam.hcount + video_pkg::hcount_t'(1);
			v_next = beam.vcount;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Registered position and flag decode
	//////////////////////////////////////////////////////////////////////

	// Reset value (0,0) with flags clear is already the decode of (0,0)
	always_ff @(posedge clk_6md) begin
		if (reset) begin
			beam <= '0;
		end else begin
			beam.hcount <= h_next;
			beam.vcount <= v_next;
			// Flags decoded from the position they travel with
			beam.hsync <= (h_next >= video_pkg::H_SYNC_START) &&
				(h_next < video_pkg::H_SYNC_END);
			beam.vsync <= (v_next >= video_pkg::V_SYNC_START) &&
				(v_next < video_pkg::V_SYNC_END);
			// Outside active area on either axis
			beam.blank <= (h_next >= video_pkg::H_ACTIVE) ||
				(v_next >= video_pkg::V_ACTIVE);
		end
	end

endmodule

/* hw/video_top.sv */
`timescale 1ns/1ps

module video_top (
	input  logic                    clk_6md,
	input  logic                    reset,
	input  video_pkg::host_wr_t     host_wr,
	output palette_pkg::video_out_t video
);

	// Timing and host side
	video_pkg::beam_t        beam;
	video_pkg::layer_wr_t    layer_wr [video_pkg::NUM_LAYERS];
	logic                    prom_rg_we;
	logic                    prom_b_we;
	palette_pkg::prom_addr_t prom_waddr;
	logic [7:0]              prom_wdata;
	logic                    bank;

	// Pixel pipeline
	video_pkg::layer_pixel_t  pixels [video_pkg::NUM_LAYERS];
	palette_pkg::clut_index_t mix_index;
	video_pkg::beam_t         mix_beam;
	palette_pkg::prom_addr_t  prom_addr;
	palette_pkg::prom_rg_t    prom_rg;
	palette_pkg::prom_b_t     prom_b;

	//////////////////////////////////////////////////////////////////////
	// Timing and host decode
	//////////////////////////////////////////////////////////////////////

	video_timing u_timing (.clk_6md(clk_6md), .reset(reset), .beam(beam));

	host_regs u_host (
		.clk_6md(clk_6md), .reset(reset), .host_wr(host_wr), .layer_wr(layer_wr),
		.prom_rg_we(prom_rg_we), .prom_b_we(prom_b_we), .prom_waddr(prom_waddr),
		.prom_wdata(prom_wdata), .bank(bank)
	);

	//////////////////////////////////////////////////////////////////////
	// Tile layers and mixer
	//////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < video_pkg::NUM_LAYERS; i++) begin : g_layer
		layer_fetch u_layer (
			.clk_6md(clk_6md), .reset(reset), .beam(beam),
			.wr(layer_wr[i]), .pixel(pixels[i])
		);
	end

	priority_mixer u_mixer (
		.clk_6md(clk_6md), .reset(reset), .beam(beam), .pixels(pixels),
		.index(mix_index), .beam_out(mix_beam)
	);

	//////////////////////////////////////////////////////////////////////
	// Colour lookup
	//////////////////////////////////////////////////////////////////////

	clut_stage u_clut (
		.clk_6md(clk_6md), .reset(reset), .index(mix_index), .beam(mix_beam),
		.bank(bank), .prom_addr(prom_addr), .prom_rg(prom_rg), .prom_b(prom_b),
		.video(video)
	);

	// Red/green PROM, full byte
	sync_rom #(.entry_t(palette_pkg::prom_rg_t)) u_prom_rg (
		.clk_6md(clk_6md), .we(prom_rg_we), .waddr(prom_waddr),
		.wdata(palette_pkg::prom_rg_t'(prom_wdata)), .raddr(prom_addr), .rdata(prom_rg)
	);

	// Blue PROM, low nibble of the host byte
	sync_rom #(.entry_t(palette_pkg::prom_b_t)) u_prom_b (
		.clk_6md(clk_6md), .we(prom_b_we), .waddr(prom_waddr),
		.wdata(palette_pkg::prom_b_t'(prom_wdata[3:0])), .raddr(prom_addr), .rdata(prom_b)
	);

endmodule

/* testbench/tb_video_model.svh */
`ifndef TB_VIDEO_MODEL_SVH
`define TB_VIDEO_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// Shadow copies of host-visible state
//////////////////////////////////////////////////////////////////////

logic [7:0]            shadow_pattern [video_pkg::NUM_LAYERS][256];
logic [7:0]            shadow_scroll  [video_pkg::NUM_LAYERS];
logic [1:0]            shadow_prio    [video_pkg::NUM_LAYERS];
palette_pkg::prom_rg_t shadow_prom_rg [palette_pkg::PROM_DEPTH];
palette_pkg::prom_b_t  shadow_prom_b  [palette_pkg::PROM_DEPTH];
logic                  shadow_bank;

// Registers that come out of reset cleared
task automatic clear_shadow_regs();
	for (int i = 0; i < video_pkg::NUM_LAYERS; i++) begin
		shadow_scroll[i] = 8'd0;
		shadow_prio[i]   = 2'd0;
	end
	shadow_bank = 1'b0;
endtask

// Mirror one host write into the model
task automatic record_host_write(input video_pkg::host_target_e target, input int layer,
	input int addr, input logic [7:0] data);
	case (target)
		video_pkg::TGT_LAYER_RAM: shadow_pattern[layer][addr % 256] = data;
		video_pkg::TGT_LAYER_CTRL: begin
			// Control slot 0 scroll, slot 1 priority
			if (addr == 0) begin
				shadow_scroll[layer] = data;
			end else if (addr == 1) begin
				shadow_prio[layer] = data[1:0];
			end
		end
		video_pkg::TGT_PROM_RG: shadow_prom_rg[addr] = data;
		video_pkg::TGT_PROM_B:  shadow_prom_b[addr] = data[3:0];
		video_pkg::TGT_BANK:    shadow_bank = data[0];
		default: ;
	endcase
endtask

// Tile cell seen by one layer at a raster position
function automatic logic [7:0] tile_color(input int layer, input int h, input int v);
	int row;
	int col;
	row = v % 16;
	col = (h + shadow_scroll[layer]) % 16;
	return shadow_pattern[layer][row * 16 + col];
endfunction

//////////////////////////////////////////////////////////////////////
// Expected video for a raster position
//////////////////////////////////////////////////////////////////////

function automatic palette_pkg::video_out_t expected_video(input int h, input int v);
	palette_pkg::video_out_t result;
	palette_pkg::prom_addr_t addr;
	logic [7:0]              index;
	int                      winner;
	// Walk priorities downward, lowest layer first within one level
	winner = -1;
	for (int p = 3; p >= 0; p--) begin
		for (int i = 0; i < video_pkg::NUM_LAYERS; i++) begin
			if ((winner < 0) && (shadow_prio[i] == p) && (tile_color(i, h, v) != 8'd0)) begin
				winner = i;
			end
		end
	end
	// Nothing opaque gives index 0
	index = (winner < 0) ? 8'd0 : tile_color(winner, h, v);
	addr.bank  = shadow_bank;
	addr.index = index;
	result.red   = shadow_prom_rg[addr].red;
	result.green = shadow_prom_rg[addr].green;
	result.blue  = shadow_prom_b[addr].blue;
	// Flags belong to the same raster position as the colour
	result.sync = ((h >= video_pkg::H_SYNC_START) && (h < video_pkg::H_SYNC_END)) ||
		((v >= video_pkg::V_SYNC_START) && (v < video_pkg::V_SYNC_END));
	result.blank = (h >= video_pkg::H_ACTIVE) || (v >= video_pkg::V_ACTIVE);
	return result;
endfunction

`endif

/* testbench/tb_video_top.sv */
`timescale 1ns/1ps

module tb_video_top;

	//////////////////////////////////////////////////////////////////////
	// Run length
	//////////////////////////////////////////////////////////////////////

	localparam int FRAME_CYCLES = video_pkg::H_TOTAL * video_pkg::V_TOTAL;
	localparam int NUM_TESTS    = 5;
	// Two pattern loads, both PROMs, scroll and priority writes, one bank write
	localparam int LOAD_WRITES  = 2 * video_pkg::NUM_LAYERS * 256 +
		2 * palette_pkg::PROM_DEPTH + 2 * video_pkg::NUM_LAYERS + 1;
	// Each test may idle up to one frame before its checked frame
	localparam int TIMEOUT_CYCLES = 2 * NUM_TESTS * FRAME_CYCLES + LOAD_WRITES + 200;
	// Quiet cycles between the last strobe and a checked frame
	localparam int QUIET_GAP = 8;

	// Pattern fill kinds
	localparam int FILL_CLEAR  = 0;
	localparam int FILL_RANDOM = 1;
	localparam int FILL_SPARSE = 2;

	logic                    clk_6md;
	logic                    reset;
	video_pkg::host_wr_t     host_wr;
	palette_pkg::video_out_t video;

	// Cycles since reset release, and a free-running watchdog count
	int cyc;
	int wd_count;

	// Checked frame and whether RGB is part of the check
	int   chk_frame;
	logic chk_full;

	int error_count;
	int check_count;
	int tests_failed;
	int seed;

	`include "tb_video_model.svh"

	video_top u_dut (
		.clk_6md(clk_6md),
		.reset(reset),
		.host_wr(host_wr),
		.video(video)
	);

	// 8 ns pixel clock
	initial begin
		clk_6md = 1'b0;
		forever #4 clk_6md = ~clk_6md;
	end

	//////////////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic check_video(input palette_pkg::video_out_t expected,
		input palette_pkg::video_out_t actual, input int h, input int v);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("FAIL %0t: video at (%0d,%0d) expected s%b b%b rgb %h%h%h got s%b b%b rgb %h%h%h",
				$time, h, v, expected.sync, expected.blank, expected.red, expected.green,
				expected.blue, actual.sync, actual.blank, actual.red, actual.green, actual.blue);
		end
	endtask

	task automatic check_flags(input palette_pkg::video_out_t expected,
		input palette_pkg::video_out_t actual, input int h, input int v);
		check_count++;
		if ((actual.sync !== expected.sync) || (actual.blank !== expected.blank)) begin
			error_count++;
			$display("FAIL %0t: flags at (%0d,%0d) expected sync %b blank %b got sync %b blank %b",
				$time, h, v, expected.sync, expected.blank, actual.sync, actual.blank);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Comparator
	//////////////////////////////////////////////////////////////////////

	// Video sampled here belongs to cycle cyc
	always @(posedge clk_6md) begin : compare_proc
		int                      pos;
		int                      frame;
		int                      h;
		int                      v;
		palette_pkg::video_out_t expected;
		if (reset) begin
			cyc <= 0;
		end else begin
			cyc <= cyc + 1;
			if (cyc >= video_pkg::PIPE_LATENCY) begin
				pos   = cyc - video_pkg::PIPE_LATENCY;
				frame = pos / FRAME_CYCLES;
				h     = pos % video_pkg::H_TOTAL;
				v     = (pos / video_pkg::H_TOTAL) % video_pkg::V_TOTAL;
				if (frame == chk_frame) begin
					expected = expected_video(h, v);
					if (chk_full) begin
						check_video(expected, video, h, v);
					end else begin
						check_flags(expected, video, h, v);
					end
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Watchdog
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk_6md) begin
		wd_count <= wd_count + 1;
	end

	initial begin
		wd_count = 0;
		wait (wd_count >= TIMEOUT_CYCLES);
		$display("timeout: comparator did not finish its frames");
		$display("Test failed");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Host write helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [7:0] random_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	// One single-cycle strobe, mirrored into the model
	task automatic host_write(input video_pkg::host_target_e target, input int layer,
		input int addr, input logic [7:0] data);
		@(posedge clk_6md);
		host_wr.strobe <= 1'b1;
		host_wr.target <= target;
		host_wr.layer  <= layer[1:0];
		host_wr.addr   <= addr[8:0];
		host_wr.data   <= data;
		record_host_write(target, layer, addr, data);
	endtask

	task automatic end_write_burst();
		@(posedge clk_6md);
		host_wr.strobe <= 1'b0;
	endtask

	task automatic fill_pattern(input int layer, input int kind);
		logic [7:0] color;
		logic [7:0] coin;
		for (int a = 0; a < 256; a++) begin
			color = random_byte();
			coin  = random_byte();
			if (kind == FILL_CLEAR) begin
				color = 8'd0;
			end else if ((kind == FILL_SPARSE) && coin[0]) begin
				// About half the cells transparent
				color = 8'd0;
			end
			host_write(video_pkg::TGT_LAYER_RAM, layer, a, color);
		end
	endtask

	// Both banks of both PROMs
	task automatic load_proms();
		for (int a = 0; a < palette_pkg::PROM_DEPTH; a++) begin
			host_write(video_pkg::TGT_PROM_RG, 0, a, random_byte());
			host_write(video_pkg::TGT_PROM_B, 0, a, random_byte());
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Frame scheduling
	//////////////////////////////////////////////////////////////////////

	task automatic wait_cycle(input int target);
		while (cyc < target) begin
			@(posedge clk_6md);
		end
	endtask

	// First frame that starts after the quiet gap
	function automatic int next_quiet_frame();
		return (cyc + QUIET_GAP + FRAME_CYCLES - 1) / FRAME_CYCLES;
	endfunction

	task automatic run_check(input int num, input string name, input logic full,
		input int frame);
		int errs_before;
		int checks_before;
		int errs;
		errs_before   = error_count;
		checks_before = check_count;
		chk_full  <= full;
		chk_frame <= frame;
		// Past the last pixel of the frame plus its pipeline
		wait_cycle((frame + 1) * FRAME_CYCLES + video_pkg::PIPE_LATENCY + 2);
		errs = error_count - errs_before;
		if (errs != 0) begin
			tests_failed++;
		end
		$display("test %0d %s: %0d pixels checked, %0d errors, %s", num, name,
			check_count - checks_before, errs, (errs == 0) ? "ok" : "mismatches seen");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin : stimulus
		logic [7:0] p_a;
		logic [7:0] p_b;
		logic [7:0] scroll;
		seed         = 32'hc66b;
		error_count  = 0;
		check_count  = 0;
		tests_failed = 0;
		reset     <= 1'b1;
		host_wr   <= '0;
		chk_frame <= -1;
		chk_full  <= 1'b0;
		clear_shadow_regs();
		repeat (2) @(posedge clk_6md);
		reset <= 1'b0;

		// Sync and blank over the first frame
		run_check(1, "raster flags", 1'b0, 0);

		// Layer 0 only, other layers transparent
		fill_pattern(0, FILL_RANDOM);
		for (int l = 1; l < video_pkg::NUM_LAYERS; l++) begin
			fill_pattern(l, FILL_CLEAR);
		end
		load_proms();
		end_write_burst();
		run_check(2, "single layer lookup", 1'b1, next_quiet_frame());

		// Horizontal scroll on every layer
		for (int l = 0; l < video_pkg::NUM_LAYERS; l++) begin
			scroll = random_byte();
			// Odd scroll always moves the tile column
			scroll[0] = 1'b1;
			host_write(video_pkg::TGT_LAYER_CTRL, l, 0, scroll);
		end
		end_write_burst();
		run_check(3, "scroll", 1'b1, next_quiet_frame());

		// Sparse layers, layers 0/2 and 1/3 share a priority
		for (int l = 0; l < video_pkg::NUM_LAYERS; l++) begin
			fill_pattern(l, FILL_SPARSE);
		end
		p_a = random_byte();
		p_b = random_byte();
		// Pairs sit on two different levels
		if (p_b[1:0] == p_a[1:0]) begin
			p_b[0] = ~p_b[0];
		end
		host_write(video_pkg::TGT_LAYER_CTRL, 0, 1, {6'd0, p_a[1:0]});
		host_write(video_pkg::TGT_LAYER_CTRL, 1, 1, {6'd0, p_b[1:0]});
		host_write(video_pkg::TGT_LAYER_CTRL, 2, 1, {6'd0, p_a[1:0]});
		host_write(video_pkg::TGT_LAYER_CTRL, 3, 1, {6'd0, p_b[1:0]});
		end_write_burst();
		run_check(4, "priority mixing", 1'b1, next_quiet_frame());

		// Upper PROM half
		host_write(video_pkg::TGT_BANK, 0, 0, 8'd1);
		end_write_burst();
		run_check(5, "bank switch", 1'b1, next_quiet_frame());

		$display("%0d tests, %0d failed, %0d pixels checked, %0d errors",
			NUM_TESTS, tests_failed, check_count, error_count);
		if ((error_count == 0) && (check_count > 0)) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* video_top.f */
+incdir+testbench
common/video_pkg.sv
common/palette_pkg.sv
hw/video_timing.sv
hw/host_regs.sv
hw/layer/layer_fetch.sv
hw/priority_mixer.sv
hw/clut/sync_rom.sv
hw/clut/clut_stage.sv
hw/video_top.sv
testbench/tb_video_top.sv
